/* hw/upscaler_settings.svh */
`ifndef UPSCALER_SETTINGS_SVH
`define UPSCALER_SETTINGS_SVH

//////////////////////////////////////////////////
// Source line geometry
//////////////////////////////////////////////////

// Visible pixels per source line
`define UPS_H_ACTIVE 64
// Source pixel strobes per line, blanking included
`define UPS_H_TOTAL 80
// One buffer word per visible pixel
`define UPS_LINE_BUF_DEPTH `UPS_H_ACTIVE

// clk_48m cycles between source pixel strobes
`define UPS_SRC_DIV 4
// Bits in each colour component
`define UPS_COMPONENT_DEPTH 4
// Output hsync width in output strobes
`define UPS_HSYNC_STROBES 8

`endif

/* hw/upscaler_pkg.sv */
`include "upscaler_settings.svh"

package upscaler_pkg;

	// Horizontal count, must hold the whole line
	localparam int X_COUNT_WIDTH = $clog2(`UPS_H_TOTAL);
	// Line buffer word address
	localparam int BUF_ADDR_WIDTH = $clog2(`UPS_LINE_BUF_DEPTH);

	typedef logic [X_COUNT_WIDTH-1:0] x_count_t;
	typedef logic [BUF_ADDR_WIDTH-1:0] buf_addr_t;
	typedef logic [`UPS_COMPONENT_DEPTH-1:0] component_t;

	// Colour view, red in the top bits
	typedef struct packed {
		component_t red;
		component_t green;
		component_t blue;
	} pixel_rgb_t;

	// Stored pixel, seen as buffer word or as colour
	typedef union packed {
		logic [3*`UPS_COMPONENT_DEPTH-1:0] raw;
		pixel_rgb_t rgb;
	} pixel_word_t;

endpackage

/* hw/source_line_tracker.sv */
`timescale 1ns/10ps
`include "upscaler_settings.svh"

module source_line_tracker import upscaler_pkg::*; (
	input  logic     clk_48m,
	input  logic     reset,
	input  logic     src_stb,
	input  logic     src_hsync,
	input  logic     src_hblank,
	input  logic     src_vsync,
	output x_count_t src_x,
	output logic     wr_en,
	output logic     line_start,
	output logic     line_active,
	output logic     frame_start
);

	// Registered syncs for edge detection
	logic hsync_q;
	logic vsync_q;
	logic hsync_fall;
	logic vsync_fall;
	// Edge seen, waiting for the next strobe
	logic hsync_pending;
	logic vsync_pending;
	// Set once the first line boundary has been found
	logic locked;
	// Position of the next strobe
	x_count_t x_count;

	assign hsync_fall = hsync_q & ~src_hsync;
	assign vsync_fall = vsync_q & ~src_vsync;

	// Line starts on the first strobe after hsync ends
	assign line_start = src_stb & (hsync_pending | hsync_fall);
	// First line of a frame follows the end of vsync
	assign frame_start = line_start & (vsync_pending | vsync_fall);

	// Line start strobe is pixel 0
	assign src_x = line_start ? '0 : x_count;

	// Only visible pixels go to the buffer
	assign wr_en = src_stb & (locked | line_start) & ~src_hblank
		& (src_x < `UPS_H_ACTIVE);

	//////////////////////////////////////////////////
	// Edge tracking and strobe count
	//////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (reset) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			hsync_pending <= 1'b0;
			vsync_pending <= 1'b0;
			locked <= 1'b0;
			x_count <= '0;
			line_active <= 1'b0;
		end else begin
			hsync_q <= src_hsync;
			vsync_q <= src_vsync;

			// Pending edges are consumed by the line start
			if (line_start)
				hsync_pending <= 1'b0;
			else if (hsync_fall)
				hsync_pending <= 1'b1;
			if (line_start)
				vsync_pending <= 1'b0;
			else if (vsync_fall)
				vsync_pending <= 1'b1;

			if (line_start)
				locked <= 1'b1;

			// Count strobes along the line
			if (src_stb && (locked || line_start))
				x_count <= src_x + 1'b1;

			// Any unblanked pixel makes the line active
			// Holds the finished line's result on the line start strobe
			if (line_start)
				line_active <= ~src_hblank;
			else if (src_stb && !src_hblank)
				line_active <= 1'b1;
		end
	end

	// Source lines never run past their nominal length
	assert property (@(posedge clk_48m) disable iff (reset)
		src_stb && locked |-> src_x < `UPS_H_TOTAL)
		else $error("source line exceeds UPS_H_TOTAL strobes");

endmodule

/* hw/doubled_line_timing.sv */
`timescale 1ns/10ps
`include "upscaler_settings.svh"

module doubled_line_timing import upscaler_pkg::*; (
	input  logic     clk_48m,
	input  logic     reset,
	input  logic     line_start,
	output logic     out_stb,
	output x_count_t out_x,
	output logic     out_h_active,
	output logic     out_hsync,
	output logic     second_half
);

	// Output strobe runs at twice the source rate
	localparam int OUT_DIV = `UPS_SRC_DIV / 2;
	localparam int PHASE_WIDTH = (OUT_DIV > 1) ? $clog2(OUT_DIV) : 1;
	localparam logic [PHASE_WIDTH-1:0] PHASE_LAST = PHASE_WIDTH'(OUT_DIV - 1);
	// Phase loaded on line start, the strobe itself is issued directly
	localparam logic [PHASE_WIDTH-1:0] PHASE_AFTER_START = PHASE_WIDTH'(1 % OUT_DIV);
	localparam x_count_t X_LAST = x_count_t'(`UPS_H_TOTAL - 1);

	// Zero phase means strobe in the next cycle
	logic [PHASE_WIDTH-1:0] phase;
	// Outputs stay quiet until the first source line
	logic running;

	//////////////////////////////////////////////////
	// Strobe divider and doubled line count
	//////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (reset) begin
			running <= 1'b0;
			phase <= '0;
			out_stb <= 1'b0;
			out_x <= '0;
			second_half <= 1'b0;
		end else if (line_start) begin
			// Realign to the source line
			running <= 1'b1;
			phase <= PHASE_AFTER_START;
			out_stb <= 1'b1;
			out_x <= '0;
			second_half <= 1'b0;
		end else if (running) begin
			out_stb <= (phase == '0);
			phase <= (phase == PHASE_LAST) ? '0 : phase + 1'b1;

			// Advance after each strobe
			if (out_stb) begin
				if (out_x != X_LAST) begin
					out_x <= out_x + 1'b1;
				end else if (!second_half) begin
					// Start the repeat line
					out_x <= '0;
					second_half <= 1'b1;
				end
				// End of repeat line holds until next line start
			end
		end
	end

	assign out_h_active = out_x < `UPS_H_ACTIVE;

	// Sync at the head of each output line
	assign out_hsync = running & (out_x < `UPS_HSYNC_STROBES);

	// Strobes stay apart across line starts
	// Breaks if the source line is not a whole number of output strobes
	assert property (@(posedge clk_48m) disable iff (reset)
		out_stb |=> !out_stb)
		else $error("output strobe in consecutive cycles");

endmodule

/* hw/line_doubler.sv */
`timescale 1ns/10ps
`include "upscaler_settings.svh"

module line_doubler import upscaler_pkg::*; (
	input  logic       clk_48m,
	input  logic       reset,
	input  logic       src_stb,
	input  x_count_t   src_x,
	input  logic       wr_en,
	input  component_t src_red,
	input  component_t src_green,
	input  component_t src_blue,
	input  logic       line_start,
	input  logic       line_active,
	input  logic       out_stb,
	input  x_count_t   out_x,
	input  logic       out_h_active,
	output component_t out_red,
	output component_t out_green,
	output component_t out_blue
);

	localparam int BUF_DEPTH = `UPS_LINE_BUF_DEPTH;

	// Ping-pong line buffers
	pixel_word_t bank0 [BUF_DEPTH];
	pixel_word_t bank1 [BUF_DEPTH];

	pixel_word_t wr_word;
	pixel_word_t rd_word;
	buf_addr_t   wr_addr;
	buf_addr_t   rd_addr;

	// Registered write bank
	logic wr_bank;
	// Bank selects in effect this cycle
	logic wr_bank_now;
	logic rd_bank_now;
	// Line in the read bank had visible pixels
	logic prev_valid;
	// Current output pixel is shown
	logic show;

	// Incoming colour packed into a buffer word
	always_comb begin
		wr_word.rgb.red = src_red;
		wr_word.rgb.green = src_green;
		wr_word.rgb.blue = src_blue;
	end

	assign wr_addr = buf_addr_t'(src_x);
	assign rd_addr = buf_addr_t'(out_x);

	// Swap takes effect on the line start strobe itself
	assign wr_bank_now = line_start ? ~wr_bank : wr_bank;
	// Reads always use the other bank
	assign rd_bank_now = ~wr_bank_now;

	//////////////////////////////////////////////////
	// Bank control
	//////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (reset) begin
			wr_bank <= 1'b0;
			prev_valid <= 1'b0;
			show <= 1'b0;
		end else begin
			if (line_start) begin
				// Just-written line becomes the read line
				wr_bank <= ~wr_bank;
				prev_valid <= line_active;
			end
			// Blank outside the active width and after blank lines
			if (out_stb)
				show <= prev_valid & out_h_active;
		end
	end

	//////////////////////////////////////////////////
	// Buffer write and read
	//////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (src_stb && wr_en) begin
			if (wr_bank_now)
				bank1[wr_addr].raw <= wr_word.raw;
			else
				bank0[wr_addr].raw <= wr_word.raw;
		end
		// Read on every output strobe in both halves of the pair
		if (out_stb)
			rd_word.raw <= rd_bank_now ? bank1[rd_addr].raw : bank0[rd_addr].raw;
	end

	// Colour held from one cycle after the strobe
	assign out_red = show ? rd_word.rgb.red : '0;
	assign out_green = show ? rd_word.rgb.green : '0;
	assign out_blue = show ? rd_word.rgb.blue : '0;

	// Writes stay inside the line buffer
	assert property (@(posedge clk_48m) disable iff (reset)
		src_stb && wr_en |-> src_x < BUF_DEPTH)
		else $error("line buffer write beyond its depth");

endmodule

/* hw/video_upscaler.sv */
`timescale 1ns/10ps

module video_upscaler import upscaler_pkg::*; (
	input  logic       clk_48m,
	input  logic       reset,
	input  logic       src_stb,
	input  component_t src_red,
	input  component_t src_green,
	input  component_t src_blue,
	input  logic       src_hsync,
	input  logic       src_vsync,
	input  logic       src_hblank,
	input  logic       src_vblank,
	output logic       out_stb,
	output component_t out_red,
	output component_t out_green,
	output component_t out_blue,
	output logic       out_hsync,
	output logic       out_vsync
);

	x_count_t src_x;
	x_count_t out_x;
	logic     wr_en;
	logic     line_start;
	logic     line_active;
	logic     frame_start;
	logic     out_h_active;
	logic     second_half;
	// Vblank lines never count as active
	logic     src_blank;

	assign src_blank = src_hblank | src_vblank;

	source_line_tracker tracker (
		.clk_48m     (clk_48m),
		.reset       (reset),
		.src_stb     (src_stb),
		.src_hsync   (src_hsync),
		.src_hblank  (src_blank),
		.src_vsync   (src_vsync),
		.src_x       (src_x),
		.wr_en       (wr_en),
		.line_start  (line_start),
		.line_active (line_active),
		.frame_start (frame_start)
	);

	doubled_line_timing timing (
		.clk_48m      (clk_48m),
		.reset        (reset),
		.line_start   (line_start),
		.out_stb      (out_stb),
		.out_x        (out_x),
		.out_h_active (out_h_active),
		.out_hsync    (out_hsync),
		.second_half  (second_half)
	);

	line_doubler doubler (
		.clk_48m      (clk_48m),
		.reset        (reset),
		.src_stb      (src_stb),
		.src_x        (src_x),
		.wr_en        (wr_en),
		.src_red      (src_red),
		.src_green    (src_green),
		.src_blue     (src_blue),
		.line_start   (line_start),
		.line_active  (line_active),
		.out_stb      (out_stb),
		.out_x        (out_x),
		.out_h_active (out_h_active),
		.out_red      (out_red),
		.out_green    (out_green),
		.out_blue     (out_blue)
	);

	// Vsync follows on line boundaries, one line late like the colour
	always_ff @(posedge clk_48m) begin
		if (reset)
			out_vsync <= 1'b0;
		else if (line_start)
			out_vsync <= src_vsync;
	end

	// Each source line ends as the repeat line finishes
	assert property (@(posedge clk_48m) disable iff (reset)
		line_start && $past(out_stb) |-> second_half && !out_h_active)
		else $error("source line and doubled line pair out of step");

	// A new frame begins with output vsync released
	assert property (@(posedge clk_48m) disable iff (reset)
		frame_start |=> !out_vsync)
		else $error("output vsync still high at frame start");

endmodule

/* testbench/upscaler_tb.sv */
`timescale 1ns/10ps
`include "upscaler_settings.svh"

module upscaler_tb;

	localparam int CLK_PERIOD = 20;
	localparam int STIM_DELAY = 2;
	localparam int LINES_PER_FRAME = 12;
	localparam int RANDOM_FRAMES = 3;
	localparam int HSYNC_FIRST_X = 72;
	localparam int VSYNC_EDGE_X = 40;
	localparam int PIXEL_BITS = 3 * `UPS_COMPONENT_DEPTH;
	// All frames plus lead-in and a margin
	localparam int WATCHDOG_NS = (RANDOM_FRAMES + 2) * LINES_PER_FRAME * `UPS_H_TOTAL
		* `UPS_SRC_DIV * CLK_PERIOD + 20000;

	logic clk_48m = 1'b0;
	logic reset;
	logic src_stb;
	logic [`UPS_COMPONENT_DEPTH-1:0] src_red;
	logic [`UPS_COMPONENT_DEPTH-1:0] src_green;
	logic [`UPS_COMPONENT_DEPTH-1:0] src_blue;
	logic src_hsync;
	logic src_vsync;
	logic src_hblank;
	logic src_vblank;
	logic out_stb;
	logic [`UPS_COMPONENT_DEPTH-1:0] out_red;
	logic [`UPS_COMPONENT_DEPTH-1:0] out_green;
	logic [`UPS_COMPONENT_DEPTH-1:0] out_blue;
	logic out_hsync;
	logic out_vsync;

	// Copies of source lines indexed by line parity
	logic [PIXEL_BITS-1:0] line_pix [2][`UPS_H_ACTIVE];
	logic line_act [2];
	int src_line_count;
	int cur_line_idx;
	// High during the cycle of a line start strobe
	logic start_now;
	logic [31:0] rand_state;

	// Output monitor state
	logic monitor_on;
	logic started;
	logic pend;
	logic hs_prev;
	logic pair_valid;
	logic vs_exp;
	logic [PIXEL_BITS-1:0] pend_exp;
	int pend_x;
	int pair_par;
	int strobe_cnt;
	int hs_strobes;
	int hs_edges;
	int errors;
	int pixels_checked;
	int pairs_checked;

	video_upscaler UUT (
		.clk_48m    (clk_48m),
		.reset      (reset),
		.src_stb    (src_stb),
		.src_red    (src_red),
		.src_green  (src_green),
		.src_blue   (src_blue),
		.src_hsync  (src_hsync),
		.src_vsync  (src_vsync),
		.src_hblank (src_hblank),
		.src_vblank (src_vblank),
		.out_stb    (out_stb),
		.out_red    (out_red),
		.out_green  (out_green),
		.out_blue   (out_blue),
		.out_hsync  (out_hsync),
		.out_vsync  (out_vsync)
	);

	always #(CLK_PERIOD / 2) clk_48m = ~clk_48m;

	// LCG step for each random frame
	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Odd x factor keeps every x distinct within a line
	function automatic logic [PIXEL_BITS-1:0] pattern_pixel(input logic [31:0] mix,
		input int line, input int x);
		logic [PIXEL_BITS-1:0] base;
		base = PIXEL_BITS'(line * 12'h135) ^ PIXEL_BITS'(x * 12'h0b7);
		return base ^ mix[19:8];
	endfunction

	task automatic report_mismatch(input string what, input int got, input int want);
		errors++;
		$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, want);
	endtask

	//////////////////////////////////////////////////
	// Source video generator
	//////////////////////////////////////////////////

	// Strobes from first_x to the end of the line
	task automatic send_line(input logic [31:0] mix, input int line, input int first_x);
		logic [PIXEL_BITS-1:0] pix;
		logic v_active;
		v_active = (line >= 2) && (line <= 9);
		for (int x = first_x; x < `UPS_H_TOTAL; x++) begin
			pix = pattern_pixel(mix, line, x);
			@(posedge clk_48m);
			#STIM_DELAY;
			if (x == 0) begin
				src_line_count++;
				cur_line_idx = line;
				line_act[src_line_count % 2] = v_active;
			end
			start_now = (x == 0);
			src_stb = 1'b1;
			{src_red, src_green, src_blue} = pix;
			// Hsync ends right before pixel 0
			src_hsync = (x >= HSYNC_FIRST_X);
			// Vsync spans the frame boundary and falls mid line 0
			src_vsync = (line == LINES_PER_FRAME - 1 && x >= VSYNC_EDGE_X)
				|| (line == 0 && x < VSYNC_EDGE_X);
			src_hblank = (x >= `UPS_H_ACTIVE);
			src_vblank = !v_active;
			// Prediction copy of visible pixels
			if (v_active && x < `UPS_H_ACTIVE)
				line_pix[src_line_count % 2][x] = pix;
			repeat (`UPS_SRC_DIV - 1) begin
				@(posedge clk_48m);
				#STIM_DELAY;
				src_stb = 1'b0;
				start_now = 1'b0;
			end
		end
	endtask

	task automatic send_frame(input logic [31:0] mix);
		for (int line = 0; line < LINES_PER_FRAME; line++)
			send_line(mix, line, 0);
	endtask

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////

	// Strobe and hsync totals over the pair just finished
	task automatic check_line_timing();
		pairs_checked++;
		if (strobe_cnt != 2 * `UPS_H_TOTAL)
			report_mismatch("out_stb count per source line", strobe_cnt, 2 * `UPS_H_TOTAL);
		if (hs_edges != 2)
			report_mismatch("out_hsync pulses per source line", hs_edges, 2);
		if (hs_strobes != 2 * `UPS_HSYNC_STROBES)
			report_mismatch("out_hsync strobes per source line", hs_strobes,
				2 * `UPS_HSYNC_STROBES);
	endtask

	// Sampled mid cycle away from both edges
	always @(negedge clk_48m) begin
		if (!reset && monitor_on) begin
			// Colour one cycle after the strobe
			if (pend) begin
				pixels_checked++;
				if ({out_red, out_green, out_blue} != pend_exp)
					report_mismatch($sformatf("colour at out_x %0d", pend_x),
						{out_red, out_green, out_blue}, pend_exp);
				pend = 1'b0;
			end
			if (!started && {out_stb, out_hsync, out_vsync, out_red, out_green, out_blue} != '0)
				report_mismatch("outputs before first line start",
					{out_stb, out_hsync, out_vsync, out_red, out_green, out_blue}, 0);
			if (start_now) begin
				if (started)
					check_line_timing();
				started = 1'b1;
				// Pair shows the line before this one
				pair_par = (src_line_count + 1) % 2;
				pair_valid = line_act[pair_par];
				vs_exp = (cur_line_idx == 0);
				strobe_cnt = 0;
				hs_strobes = 0;
				hs_edges = 0;
			end
			if (out_stb && started) begin
				pend_x = strobe_cnt % `UPS_H_TOTAL;
				pend_exp = (pair_valid && pend_x < `UPS_H_ACTIVE) ? line_pix[pair_par][pend_x] : '0;
				pend = 1'b1;
				if (out_hsync)
					hs_strobes++;
				if (out_vsync != vs_exp)
					report_mismatch("out_vsync", out_vsync, vs_exp);
				strobe_cnt++;
			end
			if (out_hsync && !hs_prev)
				hs_edges++;
			hs_prev = out_hsync;
		end
	end

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	// Idle and then a blank line tail without a line start
	task automatic test_quiet_after_reset();
		repeat (20) @(posedge clk_48m);
		send_line(32'h0, LINES_PER_FRAME - 1, 60);
		@(negedge clk_48m);
		if ({out_stb, out_hsync, out_vsync, out_red, out_green, out_blue} != '0)
			report_mismatch("outputs after lead-in",
				{out_stb, out_hsync, out_vsync, out_red, out_green, out_blue}, 0);
	endtask

	// Fixed pattern checked by the monitor for colour, sync and strobes
	task automatic test_pattern_frame();
		send_frame(32'h0);
	endtask

	// New colours every frame expose a stale bank
	task automatic test_random_frames();
		for (int f = 0; f < RANDOM_FRAMES; f++) begin
			rand_state = next_random(rand_state);
			send_frame(rand_state);
		end
	endtask

	initial begin
		reset = 1'b1;
		src_stb = 1'b0;
		{src_red, src_green, src_blue} = '0;
		src_hsync = 1'b0;
		src_vsync = 1'b0;
		src_hblank = 1'b1;
		src_vblank = 1'b1;
		start_now = 1'b0;
		monitor_on = 1'b0;
		started = 1'b0;
		pend = 1'b0;
		hs_prev = 1'b0;
		line_act[0] = 1'b0;
		line_act[1] = 1'b0;
		src_line_count = 0;
		cur_line_idx = 0;
		strobe_cnt = 0;
		errors = 0;
		pixels_checked = 0;
		pairs_checked = 0;
		rand_state = 32'h52a0_544b;
		repeat (10) @(posedge clk_48m);
		#STIM_DELAY;
		reset = 1'b0;
		monitor_on = 1'b1;
		test_quiet_after_reset();
		test_pattern_frame();
		test_random_frames();
		// Last strobe's colour still to be seen
		repeat (2) @(posedge clk_48m);
		#STIM_DELAY;
		monitor_on = 1'b0;
		$display("Pixels checked: %0d, line pairs checked: %0d, errors: %0d",
			pixels_checked, pairs_checked, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns, errors so far: %0d",
			WATCHDOG_NS, errors);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+hw
hw/upscaler_pkg.sv
hw/source_line_tracker.sv
hw/doubled_line_timing.sv
hw/line_doubler.sv
hw/video_upscaler.sv
testbench/upscaler_tb.sv
